// ==== source/ray_pkg.sv ====
`default_nettype none

package ray_pkg;

  // Signed Q8.8 coordinate or direction component
  typedef logic signed [15:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // Unsigned colour fraction where 255 stands for one
  typedef logic [7:0] chan_t;

  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } color_t;

  // Per-channel reflectance and emitted light of a surface
  typedef struct packed {
    color_t reflect;
    color_t emit;
  } material_t;

  // Plane normal axis, code 3 is never stored
  typedef logic [1:0] axis_t;

  localparam axis_t AXIS_X = 2'd0;
  localparam axis_t AXIS_Y = 2'd1;
  localparam axis_t AXIS_Z = 2'd2;

  // Axis-aligned plane at position offset along its axis
  typedef struct packed {
    axis_t     axis;
    coord_t    offset;
    material_t mat;
  } object_t;

  // Scene size
  localparam int NUM_OBJECTS = 4;
  localparam int OBJ_INDEX_W = 2;

  // Reflections before a ray is retired
  localparam int MAX_BOUNCES = 4;

  // Pixel tag widths
  localparam int PIX_H_W = 11;
  localparam int PIX_V_W = 10;

  // Quotient bits per division
  localparam int DIV_STEPS = 24;

  // Colour of a fresh primary ray
  localparam color_t WHITE = '{r: 8'hff, g: 8'hff, b: 8'hff};

endpackage

`default_nettype wire

// ==== source/scene_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module scene_buffer (
  input wire clk,
  input wire rst,

  // Loader write port
  input wire wr,
  input wire [ray_pkg::OBJ_INDEX_W-1:0] wr_index,
  input ray_pkg::object_t wr_obj,

  // Intersector read port, one cycle latency
  input wire [ray_pkg::OBJ_INDEX_W-1:0] rd_index,
  output ray_pkg::object_t rd_obj
);

  ray_pkg::object_t slots [ray_pkg::NUM_OBJECTS];

  // Empty slots are black planes that absorb everything
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ray_pkg::NUM_OBJECTS; i++) begin
        slots[i] <= '0;
      end
    end else if (wr) begin
      slots[wr_index] <= wr_obj;
    end
  end

  always_ff @(posedge clk) begin
    rd_obj <= slots[rd_index];
  end

  // Loader must only send x, y or z planes
  a_axis_code: assert property (@(posedge clk) disable iff (rst)
    wr |-> wr_obj.axis != 2'd3);

endmodule

`default_nettype wire

// ==== source/fix_divider.sv ====
`timescale 1ns/100ps
`default_nettype none

module fix_divider (
  input wire clk,
  input wire rst,
  input wire start,
  input wire [ray_pkg::DIV_STEPS-1:0] dividend,
  input wire [15:0] divisor,
  output ray_pkg::coord_t quotient,
  output logic overflow,
  output logic done
);

  logic busy;
  logic [$clog2(ray_pkg::DIV_STEPS)-1:0] step;

  // Dividend bits leave at the top while quotient bits enter at the bottom
  logic [ray_pkg::DIV_STEPS-1:0] shreg;
  logic [15:0] den;
  logic [15:0] rem;
  logic [16:0] trial;
  logic fits;

  assign trial = {rem, shreg[ray_pkg::DIV_STEPS-1]};
  assign fits = trial >= {1'b0, den};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (int'(step) == ray_pkg::DIV_STEPS - 1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // One restoring step per cycle
  always_ff @(posedge clk) begin
    if (start) begin
      shreg <= dividend;
      den <= divisor;
      rem <= '0;
    end else if (busy) begin
      shreg <= {shreg[ray_pkg::DIV_STEPS-2:0], fits};
      rem <= fits ? 16'(trial - {1'b0, den}) : trial[15:0];
    end
  end

  assign quotient = ray_pkg::coord_t'(shreg[15:0]);
  // Anything at or above bit 15 does not fit a positive Q8.8 value
  assign overflow = |shreg[ray_pkg::DIV_STEPS-1:15];

  a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

  // Fixed latency that the intersector relies on
  a_latency: assert property (@(posedge clk) disable iff (rst)
    start |-> ##(ray_pkg::DIV_STEPS + 1) done);

endmodule

`default_nettype wire

// ==== source/ray_intersector.sv ====
`timescale 1ns/100ps
`default_nettype none

module ray_intersector (
  input wire clk,
  input wire rst,

  input ray_pkg::vec3_t ray_origin,
  input ray_pkg::vec3_t ray_dir,
  input wire ray_valid,

  // Scene buffer
  output logic [ray_pkg::OBJ_INDEX_W-1:0] obj_index,
  input ray_pkg::object_t obj,

  // Divider
  output logic div_start,
  output logic [ray_pkg::DIV_STEPS-1:0] div_dividend,
  output logic [15:0] div_divisor,
  input ray_pkg::coord_t div_quotient,
  input wire div_overflow,
  input wire div_done,

  output logic hit_valid,
  output logic hit_any,
  output ray_pkg::vec3_t hit_pos,
  output ray_pkg::axis_t hit_axis,
  output ray_pkg::material_t hit_mat
);

  typedef enum logic [2:0] {IDLE, FETCH, TEST, DIVIDE, FINISH} intx_state_t;

  intx_state_t state;
  logic [ray_pkg::OBJ_INDEX_W-1:0] idx;
  logic last_obj;

  // Current plane against the ray
  ray_pkg::coord_t cand_dir;
  ray_pkg::coord_t cand_org;
  logic [16:0] gap;
  logic [16:0] gap_mag;
  logic skip;
  logic closer;

  // Nearest hit so far
  logic best_any;
  ray_pkg::coord_t best_t;
  ray_pkg::axis_t best_axis;
  ray_pkg::coord_t best_offset;
  ray_pkg::material_t best_mat;

  function automatic ray_pkg::coord_t pick(
    input ray_pkg::vec3_t v,
    input ray_pkg::axis_t a
  );
    case (a)
      ray_pkg::AXIS_X: return v.x;
      ray_pkg::AXIS_Y: return v.y;
      default: return v.z;
    endcase
  endfunction

  // Hit coordinate on one axis, the plane axis lands exactly on the offset
  function automatic ray_pkg::coord_t hit_comp(
    input ray_pkg::coord_t org,
    input ray_pkg::coord_t dir,
    input logic on_axis
  );
    logic signed [31:0] prod;
    prod = best_t * dir;
    if (on_axis) begin
      return best_offset;
    end
    return org + ray_pkg::coord_t'(prod[23:8]);
  endfunction

  assign obj_index = idx;
  assign last_obj = (int'(idx) == ray_pkg::NUM_OBJECTS - 1);

  assign cand_dir = pick(ray_dir, obj.axis);
  assign cand_org = pick(ray_origin, obj.axis);

  // 17 bits so the difference of two Q8.8 values cannot wrap
  assign gap = {obj.offset[15], obj.offset} - {cand_org[15], cand_org};
  assign gap_mag = gap[16] ? -gap : gap;

  // Parallel ray, origin on the plane, or plane behind the ray
  assign skip = (cand_dir == '0) || (gap == '0) || (gap[16] != cand_dir[15]);

  assign div_dividend = {gap_mag[15:0], 8'h00};
  assign div_divisor = cand_dir[15] ? 16'(-cand_dir) : 16'(cand_dir);

  // Strict compare keeps the lower index on equal distance
  assign closer = !div_overflow && (!best_any || div_quotient < best_t);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      idx <= '0;
      best_any <= 1'b0;
      div_start <= 1'b0;
      hit_valid <= 1'b0;
      hit_any <= 1'b0;
    end else begin
      div_start <= 1'b0;
      hit_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            idx <= '0;
            best_any <= 1'b0;
            state <= FETCH;
          end
        end
        FETCH: begin
          // Scene buffer read in flight
          state <= TEST;
        end
        TEST: begin
          if (!skip) begin
            div_start <= 1'b1;
            state <= DIVIDE;
          end else if (last_obj) begin
            state <= FINISH;
          end else begin
            idx <= idx + 1'b1;
            state <= FETCH;
          end
        end
        DIVIDE: begin
          if (div_done) begin
            if (closer) begin
              best_any <= 1'b1;
              best_t <= div_quotient;
              best_axis <= obj.axis;
              best_offset <= obj.offset;
              best_mat <= obj.mat;
            end
            if (last_obj) begin
              state <= FINISH;
            end else begin
              idx <= idx + 1'b1;
              state <= FETCH;
            end
          end
        end
        FINISH: begin
          hit_valid <= 1'b1;
          hit_any <= best_any;
          hit_pos.x <= hit_comp(ray_origin.x, ray_dir.x, best_axis == ray_pkg::AXIS_X);
          hit_pos.y <= hit_comp(ray_origin.y, ray_dir.y, best_axis == ray_pkg::AXIS_Y);
          hit_pos.z <= hit_comp(ray_origin.z, ray_dir.z, best_axis == ray_pkg::AXIS_Z);
          hit_axis <= best_axis;
          hit_mat <= best_mat;
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/ray_reflector.sv ====
`timescale 1ns/100ps
`default_nettype none

module ray_reflector (
  input wire clk,
  input wire rst,

  input ray_pkg::vec3_t ray_dir,
  input ray_pkg::color_t ray_color,
  input ray_pkg::color_t income_light,

  input ray_pkg::vec3_t hit_pos,
  input ray_pkg::axis_t hit_axis,
  input ray_pkg::material_t hit_mat,
  input wire hit_valid,

  output ray_pkg::vec3_t new_dir,
  output ray_pkg::vec3_t new_origin,
  output ray_pkg::color_t new_color,
  output ray_pkg::color_t new_income_light,
  output logic reflect_done
);

  // Product of two unit fractions
  function automatic ray_pkg::chan_t scale(
    input ray_pkg::chan_t a,
    input ray_pkg::chan_t b
  );
    logic [15:0] prod;
    prod = a * b;
    return prod[15:8];
  endfunction

  function automatic ray_pkg::chan_t add_sat(
    input ray_pkg::chan_t a,
    input ray_pkg::chan_t b
  );
    logic [8:0] sum;
    sum = a + b;
    return sum[8] ? 8'hff : sum[7:0];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      reflect_done <= 1'b0;
    end else begin
      reflect_done <= hit_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_valid) begin
      // Mirror flips only the normal component
      new_dir.x <= (hit_axis == ray_pkg::AXIS_X) ? -ray_dir.x : ray_dir.x;
      new_dir.y <= (hit_axis == ray_pkg::AXIS_Y) ? -ray_dir.y : ray_dir.y;
      new_dir.z <= (hit_axis == ray_pkg::AXIS_Z) ? -ray_dir.z : ray_dir.z;
      new_origin <= hit_pos;

      new_color.r <= scale(ray_color.r, hit_mat.reflect.r);
      new_color.g <= scale(ray_color.g, hit_mat.reflect.g);
      new_color.b <= scale(ray_color.b, hit_mat.reflect.b);

      // Emission seen through the current ray filter
      new_income_light.r <= add_sat(income_light.r, scale(ray_color.r, hit_mat.emit.r));
      new_income_light.g <= add_sat(income_light.g, scale(ray_color.g, hit_mat.emit.g));
      new_income_light.b <= add_sat(income_light.b, scale(ray_color.b, hit_mat.emit.b));
    end
  end

endmodule

`default_nettype wire

// ==== source/ray_tracer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ray_tracer (
  input wire clk,
  input wire rst,

  input wire ray_valid,
  input ray_pkg::vec3_t ray_origin,
  input ray_pkg::vec3_t ray_dir,
  input wire [ray_pkg::PIX_H_W-1:0] pixel_h_in,
  input wire [ray_pkg::PIX_V_W-1:0] pixel_v_in,

  output logic ray_busy,
  output logic ray_done,
  output ray_pkg::color_t pixel_color,
  output logic [ray_pkg::PIX_H_W-1:0] pixel_h_out,
  output logic [ray_pkg::PIX_V_W-1:0] pixel_v_out,

  // Intersector side
  output logic intx_valid,
  output ray_pkg::vec3_t cur_origin,
  output ray_pkg::vec3_t cur_dir,
  input wire intx_done,
  input wire intx_hit_any,
  input ray_pkg::vec3_t intx_hit_pos,
  input ray_pkg::axis_t intx_hit_axis,
  input ray_pkg::material_t intx_hit_mat,

  // Reflector side
  output logic rflx_valid,
  output ray_pkg::color_t cur_color,
  output ray_pkg::color_t cur_light,
  input wire rflx_done,
  input ray_pkg::vec3_t rflx_dir,
  input ray_pkg::vec3_t rflx_origin,
  input ray_pkg::color_t rflx_color,
  input ray_pkg::color_t rflx_light
);

  typedef enum logic [1:0] {IDLE, INTX, REFLECT} tracer_state_t;

  tracer_state_t state;
  logic [$clog2(ray_pkg::MAX_BOUNCES)-1:0] bounce_count;

  assign ray_busy = (state != IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      intx_valid <= 1'b0;
      rflx_valid <= 1'b0;
      ray_done <= 1'b0;
      bounce_count <= '0;
    end else begin
      intx_valid <= 1'b0;
      rflx_valid <= 1'b0;
      ray_done <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            cur_origin <= ray_origin;
            cur_dir <= ray_dir;
            cur_color <= ray_pkg::WHITE;
            cur_light <= '0;
            // Tags ride along with the ray
            pixel_h_out <= pixel_h_in;
            pixel_v_out <= pixel_v_in;
            bounce_count <= '0;
            intx_valid <= 1'b1;
            state <= INTX;
          end
        end
        INTX: begin
          if (intx_done) begin
            if (intx_hit_any) begin
              rflx_valid <= 1'b1;
              state <= REFLECT;
            end else begin
              // Escaped the scene
              pixel_color <= cur_light;
              ray_done <= 1'b1;
              state <= IDLE;
            end
          end
        end
        REFLECT: begin
          if (rflx_done) begin
            cur_dir <= rflx_dir;
            cur_origin <= rflx_origin;
            cur_color <= rflx_color;
            cur_light <= rflx_light;
            if (int'(bounce_count) == ray_pkg::MAX_BOUNCES - 1) begin
              pixel_color <= rflx_light;
              ray_done <= 1'b1;
              state <= IDLE;
            end else begin
              bounce_count <= bounce_count + 1'b1;
              intx_valid <= 1'b1;
              state <= INTX;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) ray_done |=> !ray_done);

  // Reflector is busy for exactly one cycle after its strobe
  a_rflx_latency: assert property (@(posedge clk) disable iff (rst)
    rflx_valid |=> rflx_done && !rflx_valid && !intx_valid);

  // Intersector results feed the reflector directly and must hold meanwhile
  a_hit_hold: assert property (@(posedge clk) disable iff (rst)
    state == REFLECT |-> $stable(intx_hit_pos) && $stable(intx_hit_axis)
      && $stable(intx_hit_mat));

endmodule

`default_nettype wire

// ==== source/ray_trace_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ray_trace_top (
  input wire clk,
  input wire rst,

  // Ray request
  input wire ray_valid,
  input ray_pkg::vec3_t ray_origin,
  input ray_pkg::vec3_t ray_dir,
  input wire [ray_pkg::PIX_H_W-1:0] pixel_h_in,
  input wire [ray_pkg::PIX_V_W-1:0] pixel_v_in,
  output logic ray_busy,

  // Result
  output logic ray_done,
  output ray_pkg::color_t pixel_color,
  output logic [ray_pkg::PIX_H_W-1:0] pixel_h_out,
  output logic [ray_pkg::PIX_V_W-1:0] pixel_v_out,

  // Scene loading
  input wire scene_wr,
  input wire [ray_pkg::OBJ_INDEX_W-1:0] scene_wr_index,
  input ray_pkg::object_t scene_wr_obj
);

  logic intx_valid;
  logic intx_done;
  logic intx_hit_any;
  ray_pkg::vec3_t cur_origin;
  ray_pkg::vec3_t cur_dir;
  ray_pkg::vec3_t intx_hit_pos;
  ray_pkg::axis_t intx_hit_axis;
  ray_pkg::material_t intx_hit_mat;

  logic rflx_valid;
  logic rflx_done;
  ray_pkg::color_t cur_color;
  ray_pkg::color_t cur_light;
  ray_pkg::vec3_t rflx_dir;
  ray_pkg::vec3_t rflx_origin;
  ray_pkg::color_t rflx_color;
  ray_pkg::color_t rflx_light;

  logic [ray_pkg::OBJ_INDEX_W-1:0] obj_index;
  ray_pkg::object_t obj;

  logic div_start;
  logic div_done;
  logic div_overflow;
  logic [ray_pkg::DIV_STEPS-1:0] div_dividend;
  logic [15:0] div_divisor;
  ray_pkg::coord_t div_quotient;

  ray_tracer tracer0 (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .ray_origin(ray_origin),
    .ray_dir(ray_dir),
    .pixel_h_in(pixel_h_in),
    .pixel_v_in(pixel_v_in),
    .ray_busy(ray_busy),
    .ray_done(ray_done),
    .pixel_color(pixel_color),
    .pixel_h_out(pixel_h_out),
    .pixel_v_out(pixel_v_out),
    .intx_valid(intx_valid),
    .cur_origin(cur_origin),
    .cur_dir(cur_dir),
    .intx_done(intx_done),
    .intx_hit_any(intx_hit_any),
    .intx_hit_pos(intx_hit_pos),
    .intx_hit_axis(intx_hit_axis),
    .intx_hit_mat(intx_hit_mat),
    .rflx_valid(rflx_valid),
    .cur_color(cur_color),
    .cur_light(cur_light),
    .rflx_done(rflx_done),
    .rflx_dir(rflx_dir),
    .rflx_origin(rflx_origin),
    .rflx_color(rflx_color),
    .rflx_light(rflx_light)
  );

  ray_intersector intx0 (
    .clk(clk),
    .rst(rst),
    .ray_origin(cur_origin),
    .ray_dir(cur_dir),
    .ray_valid(intx_valid),
    .obj_index(obj_index),
    .obj(obj),
    .div_start(div_start),
    .div_dividend(div_dividend),
    .div_divisor(div_divisor),
    .div_quotient(div_quotient),
    .div_overflow(div_overflow),
    .div_done(div_done),
    .hit_valid(intx_done),
    .hit_any(intx_hit_any),
    .hit_pos(intx_hit_pos),
    .hit_axis(intx_hit_axis),
    .hit_mat(intx_hit_mat)
  );

  // Reflector reads hit data straight from the intersector
  ray_reflector rflx0 (
    .clk(clk),
    .rst(rst),
    .ray_dir(cur_dir),
    .ray_color(cur_color),
    .income_light(cur_light),
    .hit_pos(intx_hit_pos),
    .hit_axis(intx_hit_axis),
    .hit_mat(intx_hit_mat),
    .hit_valid(rflx_valid),
    .new_dir(rflx_dir),
    .new_origin(rflx_origin),
    .new_color(rflx_color),
    .new_income_light(rflx_light),
    .reflect_done(rflx_done)
  );

  fix_divider div0 (
    .clk(clk),
    .rst(rst),
    .start(div_start),
    .dividend(div_dividend),
    .divisor(div_divisor),
    .quotient(div_quotient),
    .overflow(div_overflow),
    .done(div_done)
  );

  scene_buffer scene0 (
    .clk(clk),
    .rst(rst),
    .wr(scene_wr),
    .wr_index(scene_wr_index),
    .wr_obj(scene_wr_obj),
    .rd_index(obj_index),
    .rd_obj(obj)
  );

endmodule

`default_nettype wire

// ==== verification/ray_trace_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ray_trace_tb;

  localparam logic [31:0] LFSR_SEED = 32'd84439;
  // Galois form of x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  localparam int RAY_COUNT = 111;
  localparam int WORST_RAY_CYCLES = (ray_pkg::MAX_BOUNCES + 1) * ray_pkg::NUM_OBJECTS * 28
    + 2 * ray_pkg::MAX_BOUNCES + 8;
  localparam int TIMEOUT_CYCLES = RAY_COUNT * WORST_RAY_CYCLES * 2;

  typedef struct packed {
    ray_pkg::color_t color;
    logic [ray_pkg::PIX_H_W-1:0] h;
    logic [ray_pkg::PIX_V_W-1:0] v;
  } expect_t;

  logic clk;
  logic rst;
  logic ray_valid;
  ray_pkg::vec3_t ray_origin;
  ray_pkg::vec3_t ray_dir;
  logic [ray_pkg::PIX_H_W-1:0] pixel_h_in;
  logic [ray_pkg::PIX_V_W-1:0] pixel_v_in;
  logic ray_busy;
  logic ray_done;
  ray_pkg::color_t pixel_color;
  logic [ray_pkg::PIX_H_W-1:0] pixel_h_out;
  logic [ray_pkg::PIX_V_W-1:0] pixel_v_out;
  logic scene_wr;
  logic [ray_pkg::OBJ_INDEX_W-1:0] scene_wr_index;
  ray_pkg::object_t scene_wr_obj;

  // Model copy of the scene buffer
  ray_pkg::object_t ref_scene [ray_pkg::NUM_OBJECTS];
  expect_t expect_q [$];
  expect_t head;

  logic [31:0] lfsr;
  int cycle_count;
  int errors;
  int test_errors;
  int rays_checked;
  int test_rays_start;
  int tests_passed;
  int tests_failed;
  string test_name;

  ray_trace_top dut0 (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .ray_origin(ray_origin),
    .ray_dir(ray_dir),
    .pixel_h_in(pixel_h_in),
    .pixel_v_in(pixel_v_in),
    .ray_busy(ray_busy),
    .ray_done(ray_done),
    .pixel_color(pixel_color),
    .pixel_h_out(pixel_h_out),
    .pixel_v_out(pixel_v_out),
    .scene_wr(scene_wr),
    .scene_wr_index(scene_wr_index),
    .scene_wr_obj(scene_wr_obj)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return val;
  endfunction

  function automatic ray_pkg::coord_t rand_coord(input int shift);
    ray_pkg::coord_t raw;
    raw = ray_pkg::coord_t'(rand_bits(16));
    return raw >>> shift;
  endfunction

  function automatic ray_pkg::vec3_t vec(input int x, input int y, input int z);
    ray_pkg::vec3_t v;
    v.x = ray_pkg::coord_t'(x);
    v.y = ray_pkg::coord_t'(y);
    v.z = ray_pkg::coord_t'(z);
    return v;
  endfunction

  function automatic ray_pkg::object_t make_plane(
    input ray_pkg::axis_t axis,
    input int offset,
    input logic [23:0] refl,
    input logic [23:0] emit
  );
    ray_pkg::object_t o;
    o.axis = axis;
    o.offset = ray_pkg::coord_t'(offset);
    o.mat.reflect = refl;
    o.mat.emit = emit;
    return o;
  endfunction

  // Far black plane that rays with no y motion never meet
  function automatic ray_pkg::object_t blank_plane();
    return make_plane(ray_pkg::AXIS_Y, -32768, 24'h0, 24'h0);
  endfunction

  function automatic ray_pkg::object_t rand_object();
    ray_pkg::object_t o;
    o.axis = ray_pkg::axis_t'(rand_bits(2) % 3);
    o.offset = rand_coord(int'(rand_bits(2)));
    o.mat.reflect = rand_bits(24);
    o.mat.emit = rand_bits(24);
    return o;
  endfunction

  function automatic int axis_comp(input ray_pkg::vec3_t v, input ray_pkg::axis_t a);
    case (a)
      ray_pkg::AXIS_X: return int'(v.x);
      ray_pkg::AXIS_Y: return int'(v.y);
      default: return int'(v.z);
    endcase
  endfunction

  function automatic int abs_int(input int a);
    return (a < 0) ? -a : a;
  endfunction

  function automatic ray_pkg::chan_t filter(input ray_pkg::chan_t a, input ray_pkg::chan_t b);
    return ray_pkg::chan_t'((int'(a) * int'(b)) >> 8);
  endfunction

  function automatic ray_pkg::chan_t add_light(input ray_pkg::chan_t a, input ray_pkg::chan_t b);
    int sum;
    sum = int'(a) + int'(b);
    return (sum > 255) ? 8'hff : ray_pkg::chan_t'(sum);
  endfunction

  function automatic ray_pkg::coord_t advance(input ray_pkg::coord_t o, input ray_pkg::coord_t d,
                                              input int t);
    return ray_pkg::coord_t'(int'(o) + ((t * int'(d)) >>> 8));
  endfunction

  // Expected light of one primary ray in the current model scene
  function automatic ray_pkg::color_t trace_ref(input ray_pkg::vec3_t org_in,
                                                input ray_pkg::vec3_t dir_in);
    ray_pkg::vec3_t org;
    ray_pkg::vec3_t dir;
    ray_pkg::vec3_t pos;
    ray_pkg::color_t col;
    ray_pkg::color_t light;
    ray_pkg::object_t hit;
    int d;
    int gap;
    int t;
    int best;
    int best_t;
    logic ended;
    org = org_in;
    dir = dir_in;
    col = ray_pkg::WHITE;
    light = '0;
    ended = 1'b0;
    for (int b = 0; b < ray_pkg::MAX_BOUNCES && !ended; b++) begin
      best = -1;
      best_t = 0;
      for (int i = 0; i < ray_pkg::NUM_OBJECTS; i++) begin
        d = axis_comp(dir, ref_scene[i].axis);
        gap = int'(ref_scene[i].offset) - axis_comp(org, ref_scene[i].axis);
        if (d != 0 && gap != 0 && ((gap < 0) == (d < 0))) begin
          t = (abs_int(gap) * 256) / abs_int(d);
          // Lower index keeps a tie
          if (t <= 32767 && (best < 0 || t < best_t)) begin
            best = i;
            best_t = t;
          end
        end
      end
      if (best < 0) begin
        ended = 1'b1;
      end else begin
        hit = ref_scene[best];
        pos.x = (hit.axis == ray_pkg::AXIS_X) ? hit.offset : advance(org.x, dir.x, best_t);
        pos.y = (hit.axis == ray_pkg::AXIS_Y) ? hit.offset : advance(org.y, dir.y, best_t);
        pos.z = (hit.axis == ray_pkg::AXIS_Z) ? hit.offset : advance(org.z, dir.z, best_t);
        if (hit.axis == ray_pkg::AXIS_X) dir.x = -dir.x;
        if (hit.axis == ray_pkg::AXIS_Y) dir.y = -dir.y;
        if (hit.axis == ray_pkg::AXIS_Z) dir.z = -dir.z;
        org = pos;
        light.r = add_light(light.r, filter(col.r, hit.mat.emit.r));
        light.g = add_light(light.g, filter(col.g, hit.mat.emit.g));
        light.b = add_light(light.b, filter(col.b, hit.mat.emit.b));
        col.r = filter(col.r, hit.mat.reflect.r);
        col.g = filter(col.g, hit.mat.reflect.g);
        col.b = filter(col.b, hit.mat.reflect.b);
      end
    end
    return light;
  endfunction

  task automatic write_obj(input int index, input ray_pkg::object_t o);
    while (ray_busy) @(negedge clk);
    scene_wr = 1'b1;
    scene_wr_index = index[ray_pkg::OBJ_INDEX_W-1:0];
    scene_wr_obj = o;
    ref_scene[index] = o;
    @(negedge clk);
    scene_wr = 1'b0;
  endtask

  task automatic fire_ray(input ray_pkg::vec3_t org, input ray_pkg::vec3_t dir,
                          input logic [ray_pkg::PIX_H_W-1:0] h,
                          input logic [ray_pkg::PIX_V_W-1:0] v);
    expect_t e;
    while (ray_busy) @(negedge clk);
    e.color = trace_ref(org, dir);
    e.h = h;
    e.v = v;
    expect_q.push_back(e);
    ray_valid = 1'b1;
    ray_origin = org;
    ray_dir = dir;
    pixel_h_in = h;
    pixel_v_in = v;
    @(negedge clk);
    ray_valid = 1'b0;
    // Busy follows one cycle after the accepted strobe
    if (ray_busy !== 1'b1) begin
      $display("** Error at %0t: ray_busy expected 1, got %b", $time, ray_busy);
      errors++;
      test_errors++;
    end
  endtask

  task automatic wait_idle();
    while (ray_busy || expect_q.size() != 0) @(negedge clk);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
    test_rays_start = rays_checked;
  endtask

  task automatic end_test();
    wait_idle();
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %s: ok, %0d rays", test_name, rays_checked - test_rays_start);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED, %0d errors", test_name, test_errors);
    end
  endtask

  task automatic test_empty_scene();
    begin_test("empty scene");
    if (ray_busy !== 1'b0) begin
      $display("** Error at %0t: ray_busy expected 0, got %b", $time, ray_busy);
      errors++;
      test_errors++;
    end
    fire_ray(vec(256, 512, 768), vec(-256, 128, 64), 11'd0, 10'd0);
    fire_ray(vec(-512, 0, 0), vec(256, 0, -256), 11'd2047, 10'd1023);
    fire_ray(vec(0, 0, 0), vec(0, 0, 0), 11'd1234, 10'd567);
    end_test();
  endtask

  task automatic test_single_plane();
    begin_test("single plane");
    write_obj(0, make_plane(ray_pkg::AXIS_X, 1024, 24'h0, 24'hc86432));
    for (int i = 1; i < ray_pkg::NUM_OBJECTS; i++) begin
      write_obj(i, blank_plane());
    end
    fire_ray(vec(0, 0, 0), vec(256, 0, 64), 11'd10, 10'd20);
    // Moving away from the plane
    fire_ray(vec(0, 0, 0), vec(-256, 0, 64), 11'd11, 10'd21);
    end_test();
  endtask

  task automatic test_bounce_limit();
    begin_test("bounce limit");
    // Red saturates early, green and blue still grow on every bounce
    write_obj(0, make_plane(ray_pkg::AXIS_X, 512, 24'hc8dcf0, 24'hfa2010));
    write_obj(1, make_plane(ray_pkg::AXIS_X, -512, 24'hf0c8dc, 24'h5a1830));
    write_obj(2, blank_plane());
    write_obj(3, blank_plane());
    fire_ray(vec(0, 0, 0), vec(256, 0, 64), 11'd100, 10'd200);
    fire_ray(vec(128, 0, -256), vec(-384, 0, 32), 11'd101, 10'd201);
    end_test();
  endtask

  task automatic test_nearest_hit();
    begin_test("nearest hit");
    write_obj(0, make_plane(ray_pkg::AXIS_X, 1536, 24'h0, 24'h112233));
    // Equal distance, index 1 must win over index 2
    write_obj(1, make_plane(ray_pkg::AXIS_X, 768, 24'h0, 24'h445566));
    write_obj(2, make_plane(ray_pkg::AXIS_X, 768, 24'h0, 24'h778899));
    write_obj(3, make_plane(ray_pkg::AXIS_X, 2304, 24'h0, 24'haabbcc));
    fire_ray(vec(0, 0, 0), vec(256, 0, 128), 11'd300, 10'd301);
    fire_ray(vec(2560, 0, 0), vec(-256, 0, 0), 11'd302, 10'd303);
    end_test();
  endtask

  task automatic test_random();
    ray_pkg::vec3_t org;
    ray_pkg::vec3_t dir;
    begin_test("random scenes");
    for (int n = 0; n < 100; n++) begin
      for (int i = 0; i < ray_pkg::NUM_OBJECTS; i++) begin
        write_obj(i, rand_object());
      end
      org.x = rand_coord(4);
      org.y = rand_coord(4);
      org.z = rand_coord(4);
      // Small components give distances that overflow
      dir.x = rand_coord(int'(rand_bits(4)));
      dir.y = rand_coord(int'(rand_bits(4)));
      dir.z = rand_coord(int'(rand_bits(4)));
      fire_ray(org, dir, 11'(rand_bits(11)), 10'(rand_bits(10)));
    end
    end_test();
  endtask

  task automatic test_busy_and_rewrite();
    begin_test("busy strobe and rewrite");
    write_obj(0, make_plane(ray_pkg::AXIS_Z, 1024, 24'h808080, 24'h30c060));
    write_obj(1, blank_plane());
    write_obj(2, blank_plane());
    write_obj(3, blank_plane());
    fire_ray(vec(0, 0, 0), vec(64, 0, 256), 11'd500, 10'd501);
    repeat (2) @(negedge clk);
    if (!ray_busy) begin
      $display("Core went idle too early to test a strobe while busy at %0t", $time);
      errors++;
      test_errors++;
    end
    // This request must be dropped
    ray_valid = 1'b1;
    pixel_h_in = 11'd777;
    pixel_v_in = 10'd888;
    @(negedge clk);
    ray_valid = 1'b0;
    wait_idle();
    write_obj(0, make_plane(ray_pkg::AXIS_Z, 512, 24'h808080, 24'hf01020));
    fire_ray(vec(0, 0, 0), vec(64, 0, 256), 11'd502, 10'd503);
    end_test();
  endtask

  // Results are stable between rising edges
  always @(negedge clk) begin
    if (!rst && ray_done) begin
      if (ray_busy !== 1'b0) begin
        $display("** Error at %0t: ray_busy expected 0, got %b", $time, ray_busy);
        errors++;
        test_errors++;
      end
      if (expect_q.size() == 0) begin
        $display("Unexpected ray_done with no ray outstanding at %0t", $time);
        errors++;
        test_errors++;
      end else begin
        head = expect_q.pop_front();
        rays_checked++;
        if (pixel_color !== head.color) begin
          $display("** Error at %0t: pixel_color expected %h, got %h",
                   $time, head.color, pixel_color);
          errors++;
          test_errors++;
        end
        if (pixel_h_out !== head.h) begin
          $display("** Error at %0t: pixel_h_out expected %0d, got %0d",
                   $time, head.h, pixel_h_out);
          errors++;
          test_errors++;
        end
        if (pixel_v_out !== head.v) begin
          $display("** Error at %0t: pixel_v_out expected %0d, got %0d",
                   $time, head.v, pixel_v_out);
          errors++;
          test_errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the core stopped returning results", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    ray_valid = 1'b0;
    ray_origin = '0;
    ray_dir = '0;
    pixel_h_in = '0;
    pixel_v_in = '0;
    scene_wr = 1'b0;
    scene_wr_index = '0;
    scene_wr_obj = '0;
    lfsr = LFSR_SEED;
    cycle_count = 0;
    errors = 0;
    test_errors = 0;
    rays_checked = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < ray_pkg::NUM_OBJECTS; i++) begin
      ref_scene[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_empty_scene();
    test_single_plane();
    test_bounce_limit();
    test_nearest_hit();
    test_random();
    test_busy_and_rewrite();

    $display("Tests passed: %0d, failed: %0d, rays checked: %0d",
             tests_passed, tests_failed, rays_checked);
    if (tests_failed == 0 && errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/ray_pkg.sv
source/scene_buffer.sv
source/fix_divider.sv
source/ray_intersector.sv
source/ray_reflector.sv
source/ray_tracer.sv
source/ray_trace_top.sv
verification/ray_trace_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ray tracing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module ray_trace_tb -f filelist.f \
  -Mdir obj_dir -o ray_trace_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/ray_trace_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0
